// File: design/uart_cmd_bridge.sv
module uart_cmd_bridge
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_t  cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  input  logic       rx,
  output logic       tx,
  output logic       read_rdy,
  output logic [7:0] read_data,
  output logic       read_err
);

  logic       tx_req;
  logic       tx_ack;
  logic [7:0] tx_byte;
  logic       rx_req;
  logic       rx_ack;
  rx_result_t rx_result;

  uart_cmd_sequencer seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_req    (tx_req),
    .tx_byte   (tx_byte),
    .tx_ack    (tx_ack),
    .rx_req    (rx_req),
    .rx_ack    (rx_ack),
    .rx_result (rx_result),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame tx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_req  (tx_req),
    .tx_byte (tx_byte),
    .tx_ack  (tx_ack),
    .tx      (tx)
  );

  uart_rx_frame rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_req    (rx_req),
    .rx_ack    (rx_ack),
    .rx_result (rx_result)
  );

endmodule

// File: design/uart_cmd_sequencer.sv
module uart_cmd_sequencer
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_t  cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  output logic       tx_req,
  output logic [7:0] tx_byte,
  input  logic       tx_ack,
  output logic       rx_req,
  input  logic       rx_ack,
  input  rx_result_t rx_result,
  output logic       read_rdy,
  output logic [7:0] read_data,
  output logic       read_err
);

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_CMD,
    SEQ_GAP,
    SEQ_DATA,
    SEQ_RX,
    SEQ_REPORT
  } seq_state_t;

  seq_state_t           state;
  uart_cmd_t            cmd_q;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic                 accept;
  logic                 rx_done;

  assign cmd_rdy = (state == SEQ_IDLE);
  assign accept  = cmd_rdy && cmd_vld;
  assign rx_done = (state == SEQ_RX) && rx_req && rx_ack;

  // Command byte first, data byte only in the second write frame
  assign tx_byte = (state == SEQ_DATA) ? cmd_q.data : {cmd_q.write, cmd_q.addr};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= SEQ_IDLE;
      gap_cnt  <= '0;
      tx_req   <= 1'b0;
      rx_req   <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      case (state)
        SEQ_IDLE:
        begin
          if (accept)
          begin
            tx_req <= 1'b1;
            state  <= SEQ_CMD;
          end
        end
        SEQ_CMD:
        begin
          if (tx_ack)
            tx_req <= 1'b0;
          else if (!tx_req)
          begin
            if (cmd_q.write)
            begin
              gap_cnt <= '0;
              state   <= SEQ_GAP;
            end
            else
            begin
              rx_req <= 1'b1;   // Arm receiver for the response
              state  <= SEQ_RX;
            end
          end
        end
        SEQ_GAP:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == GAP_LAST)
          begin
            tx_req <= 1'b1;
            state  <= SEQ_DATA;
          end
        end
        SEQ_DATA:
        begin
          if (tx_ack)
            tx_req <= 1'b0;
          else if (!tx_req)
            state <= SEQ_IDLE;
        end
        SEQ_RX:
        begin
          if (rx_done)
          begin
            rx_req   <= 1'b0;
            read_err <= rx_result.parity_err | rx_result.stop_err | rx_result.timeout;
          end
          else if (!rx_req && !rx_ack)
          begin
            read_rdy <= 1'b1;
            state    <= SEQ_REPORT;
          end
        end
        default:
        begin
          read_rdy <= 1'b0;
          state    <= SEQ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (rx_done)
      read_data <= rx_result.data;
  end

endmodule

// File: design/uart_pkg.sv
package uart_pkg;

  localparam int BIT_CYCLES   = 434;   // Clocks per serial bit
  localparam int GAP_BITS     = 16;    // Idle bits between the two write frames
  localparam int RX_WAIT_BITS = 64;    // Bit periods to wait for a response start bit

  localparam int BIT_CNT_W = $clog2(BIT_CYCLES);
  localparam int HALF_BIT  = BIT_CYCLES / 2;

  localparam int GAP_CYCLES = GAP_BITS * BIT_CYCLES;
  localparam int GAP_CNT_W  = $clog2(GAP_CYCLES);

  localparam int RX_WAIT_CYCLES = RX_WAIT_BITS * BIT_CYCLES;
  localparam int RX_WAIT_W      = $clog2(RX_WAIT_CYCLES);

  // Terminal counts, sized to their counters
  localparam logic [BIT_CNT_W-1:0] BIT_LAST     = BIT_CNT_W'(BIT_CYCLES - 1);
  localparam logic [BIT_CNT_W-1:0] HALF_LAST    = BIT_CNT_W'(HALF_BIT - 1);
  localparam logic [GAP_CNT_W-1:0] GAP_LAST     = GAP_CNT_W'(GAP_CYCLES - 1);
  localparam logic [RX_WAIT_W-1:0] RX_WAIT_LAST = RX_WAIT_W'(RX_WAIT_CYCLES - 1);

  // Host command, same layout as cmd_in[15:0]
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       stop_err;
    logic       timeout;
  } rx_result_t;

endpackage

// File: design/uart_rx_frame.sv
module uart_rx_frame
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       rx_req,
  output logic       rx_ack,
  output rx_result_t rx_result
);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_HUNT,
    RX_START,
    RX_DATA,
    RX_ACK
  } rx_state_t;

  rx_state_t            state;
  logic                 rx_meta;
  logic                 rx_s;
  logic                 rx_d;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [3:0]           bit_idx;   // 0..7 data, 8 parity, 9 stop
  logic [RX_WAIT_W-1:0] wait_cnt;
  logic [7:0]           data_sh;
  logic                 par_bit;
  logic                 fall;
  logic                 sample;
  logic                 timeout_hit;

  assign fall        = rx_d & ~rx_s;
  assign sample      = (state == RX_DATA) && (bit_cnt == BIT_LAST);
  assign timeout_hit = (state == RX_HUNT) && !fall && (wait_cnt == RX_WAIT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta  <= 1'b1;
      rx_s     <= 1'b1;
      rx_d     <= 1'b1;
      state    <= RX_IDLE;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      wait_cnt <= '0;
      rx_ack   <= 1'b0;
    end
    else
    begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      rx_d    <= rx_s;
      case (state)
        RX_IDLE:
        begin
          if (rx_req)
          begin
            wait_cnt <= '0;
            state    <= RX_HUNT;
          end
        end
        RX_HUNT:
        begin
          wait_cnt <= wait_cnt + 1'b1;
          bit_cnt  <= '0;
          if (fall)
            state <= RX_START;
          else if (timeout_hit)
          begin
            rx_ack <= 1'b1;
            state  <= RX_ACK;
          end
        end
        RX_START:
        begin
          wait_cnt <= wait_cnt + 1'b1;
          bit_cnt  <= bit_cnt + 1'b1;
          if (bit_cnt == HALF_LAST)
          begin
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s ? RX_HUNT : RX_DATA;   // Glitch goes back to hunting
          end
        end
        RX_DATA:
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (sample)
          begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 4'd1;
            if (bit_idx == 4'd9)
            begin
              rx_ack <= 1'b1;   // Middle of stop bit
              state  <= RX_ACK;
            end
          end
        end
        default:
        begin
          if (!rx_req)
          begin
            rx_ack <= 1'b0;
            state  <= RX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx < 4'd8)
        data_sh <= {rx_s, data_sh[7:1]};   // LSB first
      else if (bit_idx == 4'd8)
        par_bit <= rx_s;
      else
        rx_result <= '{data: data_sh, parity_err: ^data_sh ^ par_bit,
                       stop_err: ~rx_s, timeout: 1'b0};
    end
    else if (timeout_hit)
    begin
      rx_result <= '{data: 8'h00, parity_err: 1'b0, stop_err: 1'b0, timeout: 1'b1};
    end
  end

endmodule

// File: design/uart_tx_frame.sv
module uart_tx_frame
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_req,
  input  logic [7:0] tx_byte,
  output logic       tx_ack,
  output logic       tx
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SEND,
    TX_DONE
  } tx_state_t;

  tx_state_t            state;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [3:0]           bit_idx;   // 0 is start, 10 is stop
  logic [9:0]           shift_q;   // Remaining data, parity, stop
  logic                 start;
  logic                 bit_end;

  assign start   = (state == TX_IDLE) && tx_req;
  assign bit_end = (state == TX_SEND) && (bit_cnt == BIT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= TX_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
      tx_ack  <= 1'b0;
    end
    else
    begin
      case (state)
        TX_IDLE:
        begin
          if (tx_req)
          begin
            tx      <= 1'b0;   // Start bit
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= TX_SEND;
          end
        end
        TX_SEND:
        begin
          if (bit_end)
          begin
            bit_cnt <= '0;
            if (bit_idx == 4'd10)
            begin
              tx_ack <= 1'b1;   // Stop bit finished
              state  <= TX_DONE;
            end
            else
            begin
              tx      <= shift_q[0];
              bit_idx <= bit_idx + 4'd1;
            end
          end
          else
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default:
        begin
          if (!tx_req)
          begin
            tx_ack <= 1'b0;
            state  <= TX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
      shift_q <= {1'b1, ^tx_byte, tx_byte};   // Even parity
    else if (bit_end)
      shift_q <= {1'b1, shift_q[9:1]};
  end

endmodule

// File: list.f
design/uart_pkg.sv
design/uart_tx_frame.sv
design/uart_rx_frame.sv
design/uart_cmd_sequencer.sv
design/uart_cmd_bridge.sv
testbench/uart_cmd_bridge_properties.sv
testbench/uart_cmd_bridge_tb.sv

// File: testbench/uart_cmd_bridge_properties.sv
module uart_cmd_bridge_properties
  import uart_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy,
  input logic tx_req,
  input logic tx_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  // Line is idle whenever no command is in flight
  tx_idle_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else $error("tx low while cmd_rdy is high");

  read_rdy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy held longer than one cycle");

  busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else $error("cmd_rdy still high after a command was accepted");

  tx_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(tx_ack) |-> tx_req)
    else $error("tx_ack rose without tx_req");

endmodule

bind uart_cmd_bridge uart_cmd_bridge_properties props_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy),
  .tx_req   (tx_req),
  .tx_ack   (tx_ack)
);

// File: testbench/uart_cmd_bridge_tb.sv
module uart_cmd_bridge_tb
  import uart_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [7:0] data;
    logic       par;
    logic       stop;
  } frame_t;

  typedef struct packed {
    logic       err;
    logic [7:0] data;
  } read_res_t;

  typedef enum {RESP_GOOD, RESP_BAD_PAR, RESP_BAD_STOP, RESP_SILENT} resp_mode_t;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  logic       read_rdy;
  logic [7:0] read_data;
  logic       read_err;

  frame_t    exp_frames[$];
  frame_t    obs_frames[$];
  read_res_t exp_reads[$];
  int        frame_starts[$];   // Cycle of each start bit seen on tx
  int        cyc = 0;
  int        read_cnt = 0;
  int        held_cycles;
  int        accept_frames;
  int        checks = 0;
  int        errors = 0;
  int        tests = 0;
  int        failed = 0;
  int        test_base = 0;

  uart_cmd_bridge dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  endtask

  task automatic abort(input string why);
    errors++;
    $display("Timeout: %s", why);
    finish_run();
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_base)
      $display("Test %s: ok", name);
    else
    begin
      failed++;
      $display("Test %s: %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  function automatic logic even_parity(input logic [7:0] b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += b[i];
    return (ones % 2) == 1;   // Makes the count of ones even
  endfunction

  // Expected frames and read result for one command and one responder setting
  function automatic void predict(input uart_cmd_t c, input logic [7:0] resp,
                                  input resp_mode_t mode);
    logic [7:0] hi;
    hi = {c.write, c.addr};
    exp_frames.push_back('{data: hi, par: even_parity(hi), stop: 1'b1});
    if (c.write)
      exp_frames.push_back('{data: c.data, par: even_parity(c.data), stop: 1'b1});
    else if (mode == RESP_GOOD)
      exp_reads.push_back('{err: 1'b0, data: resp});
    else
      exp_reads.push_back('{err: 1'b1, data: resp});
  endfunction

  // Decodes tx at bit centres
  initial
  begin : line_monitor
    frame_t f;
    logic   prev;
    int     t0;
    prev = 1'b1;
    forever
    begin
      @(negedge clk);
      if (prev && !tx)
      begin
        t0 = cyc;
        repeat (HALF_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++)
        begin
          repeat (BIT_CYCLES) @(negedge clk);
          f.data[i] = tx;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        f.par = tx;
        repeat (BIT_CYCLES) @(negedge clk);
        f.stop = tx;
        obs_frames.push_back(f);
        frame_starts.push_back(t0);
      end
      prev = tx;
    end
  end

  initial
  begin : compare_proc
    frame_t    f_obs;
    frame_t    f_exp;
    read_res_t r_obs;
    read_res_t r_exp;
    forever
    begin
      @(negedge clk);
      while (obs_frames.size() > 0)
      begin
        f_obs = obs_frames.pop_front();
        check(exp_frames.size() > 0, 1'b1, "frame on tx was expected");
        if (exp_frames.size() > 0)
        begin
          f_exp = exp_frames.pop_front();
          check(f_obs, f_exp, "tx frame data, parity, stop");
        end
      end
      if (read_rdy === 1'b1)
      begin
        read_cnt++;
        r_obs = '{err: read_err, data: read_data};
        check(exp_reads.size() > 0, 1'b1, "read result was expected");
        if (exp_reads.size() > 0)
        begin
          r_exp = exp_reads.pop_front();
          check(r_obs.err, r_exp.err, "read_err");
          if (!r_exp.err)
            check(r_obs.data, r_exp.data, "read_data");
        end
      end
    end
  end

  task automatic wait_frames(input int n);
    int t;
    t = 0;
    while (frame_starts.size() < n)
    begin
      if (t == (RX_WAIT_BITS + 40) * BIT_CYCLES)
        abort("the expected frame never appeared on tx");
      @(negedge clk);
      t++;
    end
  endtask

  task automatic wait_reads(input int n);
    int t;
    t = 0;
    while (read_cnt < n)
    begin
      if (t == (RX_WAIT_BITS + 40) * BIT_CYCLES)
        abort("read_rdy never pulsed for the read");
      @(negedge clk);
      t++;
    end
  endtask

  task automatic wait_ready();
    int t;
    t = 0;
    while (!cmd_rdy)
    begin
      if (t == (RX_WAIT_BITS + 40) * BIT_CYCLES)
        abort("cmd_rdy did not return high after the command");
      @(negedge clk);
      t++;
    end
  endtask

  // Host side of the valid/ready port
  task automatic send_cmd(input uart_cmd_t c);
    int t;
    @(negedge clk);
    cmd_in  = c;
    cmd_vld = 1'b1;
    t = 0;
    while (!cmd_rdy)
    begin
      if (t == (RX_WAIT_BITS + 40) * BIT_CYCLES)
        abort("cmd_rdy stayed low with a command waiting");
      @(negedge clk);
      t++;
    end
    held_cycles   = t;
    accept_frames = frame_starts.size();
    @(negedge clk);   // Accepted on the rising edge just passed
    cmd_vld = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] b, input logic bad_par, input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, even_parity(b) ^ bad_par, b, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx = bits[i];
      repeat (BIT_CYCLES) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  task automatic run_write();
    uart_cmd_t c;
    int        nf;
    c       = uart_cmd_t'(16'($urandom()));
    c.write = 1'b1;
    nf      = frame_starts.size();
    predict(c, 8'h00, RESP_SILENT);
    send_cmd(c);
    wait_frames(nf + 2);
    check(frame_starts[nf + 1] - frame_starts[nf] >= (11 + GAP_BITS) * BIT_CYCLES, 1'b1,
          "idle gap between write frames");
    wait_ready();
    check(frame_starts.size(), nf + 2, "frames per write");
  endtask

  task automatic run_read(input resp_mode_t mode);
    uart_cmd_t  c;
    logic [7:0] resp;
    int         nf;
    int         nr;
    c       = uart_cmd_t'(16'($urandom()));
    c.write = 1'b0;
    resp    = 8'($urandom());
    nf      = frame_starts.size();
    nr      = read_cnt;
    predict(c, resp, mode);
    send_cmd(c);
    wait_frames(nf + 1);
    repeat (2 * BIT_CYCLES) @(negedge clk);   // Receiver arms after the command frame
    if (mode != RESP_SILENT)
      send_frame(resp, mode == RESP_BAD_PAR, mode == RESP_BAD_STOP);
    wait_reads(nr + 1);
    wait_ready();
    check(frame_starts.size(), nf + 1, "frames per read");
  endtask

  initial
  begin : test_seq
    uart_cmd_t c1;
    uart_cmd_t c2;
    int        nf;
    void'($urandom(32'h2d66_3d50));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check(tx, 1'b1, "tx after reset");
    check(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check(read_rdy, 1'b0, "read_rdy after reset");
    end_test("reset state");
    repeat (3) run_write();
    end_test("write");
    repeat (2) run_read(RESP_GOOD);
    end_test("good read");
    run_read(RESP_BAD_PAR);
    run_read(RESP_BAD_STOP);
    end_test("bad frames");
    run_read(RESP_SILENT);
    end_test("no answer");
    // Second write is held on cmd_vld while the first one runs
    c1       = uart_cmd_t'(16'($urandom()));
    c2       = uart_cmd_t'(16'($urandom()));
    c1.write = 1'b1;
    c2.write = 1'b1;
    nf       = frame_starts.size();
    predict(c1, 8'h00, RESP_SILENT);
    predict(c2, 8'h00, RESP_SILENT);
    send_cmd(c1);
    send_cmd(c2);
    check(held_cycles > 0, 1'b1, "second command was held back");
    check(accept_frames, nf + 2, "frames seen before second acceptance");
    wait_frames(nf + 4);
    wait_ready();
    check(frame_starts.size(), nf + 4, "frames for two queued writes");
    end_test("back-pressure");
    repeat (4) @(negedge clk);
    check(exp_frames.size(), 0, "expected frames left over");
    check(exp_reads.size(), 0, "expected reads left over");
    finish_run();
  end

endmodule
